// File: all.f
+incdir+include
verilog/ex_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/ex_stage.sv
verilog/exec_core.sv
verif/tb_exec_core.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the exec_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_exec_core -o tb_exec_core
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/tb_exec_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
	echo "run ok"
	exit 0
fi
echo "run failed, see sim.log"
exit 1

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_word(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
	end
endtask

// field by field so a mismatch names the field
task automatic check_result(input string name, input ex_result_t got, input ex_result_t exp);
	check_bit({name, " valid"}, got.valid, exp.valid);
	check_bit({name, " illegal"}, got.illegal, exp.illegal);
	check_bit({name, " take_branch"}, got.take_branch, exp.take_branch);
	check_word({name, " target_pc"}, got.target_pc, exp.target_pc);
	check_word({name, " alu_result"}, got.alu_result, exp.alu_result);
	check_word({name, " rd"}, xlen'(got.rd), xlen'(exp.rd));
	check_bit({name, " rd_wr"}, got.rd_wr, exp.rd_wr);
endtask

// two's complement order from the sign bits first
function automatic logic less_signed(input logic [xlen-1:0] a, input logic [xlen-1:0] b);
	if (a[xlen-1] != b[xlen-1])
		less_signed = a[xlen-1];
	else
		less_signed = a < b;
endfunction

// isa reference for op and op-imm, alt picks sub / sra
function automatic logic [xlen-1:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
	logic [4:0] s;
	s = b[4:0];
	case (f3)
		3'd0: alu_model = alt ? a - b : a + b;
		3'd1: alu_model = a << s;
		3'd2: alu_model = xlen'(less_signed(a, b));
		3'd3: alu_model = xlen'(a < b);
		3'd4: alu_model = a ^ b;
		3'd5: alu_model = (a >> s) | ((alt && a[xlen-1]) ? ~({xlen{1'b1}} >> s) : '0);
		3'd6: alu_model = a | b;
		default: alu_model = a & b;
	endcase
endfunction

function automatic logic branch_model(input logic [2:0] f3, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b);
	case (f3)
		3'b000: branch_model = (a == b);
		3'b001: branch_model = (a != b);
		3'b100: branch_model = less_signed(a, b);
		3'b101: branch_model = !less_signed(a, b);
		3'b110: branch_model = (a < b);
		default: branch_model = !(a < b);
	endcase
endfunction

`endif

// File: verif/tb_exec_core.sv
`timescale 1ns/1ns

module tb_exec_core;
	import ex_pkg::*;

	logic            clk;
	logic            arst_n;
	logic            inst_valid;
	logic [31:0]     inst;
	logic [xlen-1:0] inst_pc;
	ex_result_t      result;
	int              err_count;
	int              check_count;
	integer          seed;

	`include "tb_checks.svh"

	exec_core i_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (inst_pc),
		.result     (result)
	);

	always #5 clk = ~clk;  // 10 ns period

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		r_type = {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input opcode_e op);
		i_type = {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input opcode_e op);
		u_type = {imm, rd, op};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		b_type = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		j_type = {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	function automatic logic [xlen-1:0] rand_pc();
		rand_pc = $random(seed) & 32'hffff_fffc;  // word aligned
	endfunction

	task automatic wait_valid(output ex_result_t r);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!result.valid && cycles < 20);
		if (!result.valid) begin
			$display("timeout: result.valid did not rise within 20 cycles");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			if (cycles != 1) begin
				err_count++;
				$display("result.valid rose %0d cycles after the sampling edge instead of 1",
					cycles);
			end
			r = result;
		end
	endtask

	// one instruction then idle until its result shows
	task automatic issue(input logic [31:0] word, input logic [xlen-1:0] at_pc,
			output ex_result_t r);
		@(posedge clk);
		inst_valid <= 1'b1;
		inst       <= word;
		inst_pc    <= at_pc;
		@(posedge clk);
		inst_valid <= 1'b0;
		wait_valid(r);
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [xlen-1:0] value);
		logic [xlen-1:0] upper;
		ex_result_t      r;
		upper = value + 32'h800;  // rounds for the signed addi low part
		issue(u_type(upper[31:12], rd, OP_LUI), rand_pc(), r);
		issue(i_type(value[11:0], rd, 3'b000, rd, OP_IMM), rand_pc(), r);
		check_word("load alu_result", r.alu_result, value);
	endtask

	task automatic read_reg(input logic [4:0] rs, output logic [xlen-1:0] value);
		ex_result_t r;
		issue(i_type(12'h0, rs, 3'b000, 5'd0, OP_IMM), rand_pc(), r);  // addi x0
		value = r.alu_result;
	endtask

	task automatic reset_state_test();
		ex_result_t r;
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_bit("reset valid", result.valid, 1'b0);
		check_bit("reset take_branch", result.take_branch, 1'b0);
		check_bit("reset rd_wr", result.rd_wr, 1'b0);
		check_word("reset alu_result", result.alu_result, '0);
		@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_bit("idle valid", result.valid, 1'b0);
		issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd1), 32'h0, r);
		check_word("add x0 alu_result", r.alu_result, '0);
		check_bit("add x0 rd_wr", r.rd_wr, 1'b1);
	endtask

	task automatic alu_ops_test();
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] immv;
		logic [11:0]     imm12;
		logic            alt;
		ex_result_t      r;
		for (int pair = 0; pair < 4; pair++) begin
			a = $random(seed);
			b = $random(seed);
			case (pair)
				1: begin
					a[31] = 1'b1;
					b     = 31;
				end
				2: b = 0;
				3: begin
					a[31] = 1'b0;  // slt and sltu disagree
					b[31] = 1'b1;
				end
				default: ;
			endcase
			load_reg(5'd1, a);
			load_reg(5'd2, b);
			for (int f3 = 0; f3 < 8; f3++) begin
				for (int alt_i = 0; alt_i < 2; alt_i++) begin
					if (alt_i == 1 && f3 != 0 && f3 != 5)
						continue;
					alt = alt_i[0];
					issue(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3[2:0], 5'd3),
						rand_pc(), r);
					check_word("op alu_result", r.alu_result, alu_model(f3[2:0], alt, a, b));
					check_bit("op illegal", r.illegal, 1'b0);
					if (f3 == 0 && alt)
						continue;  // no subi
					if (f3 == 1 || f3 == 5) begin
						imm12 = {alt ? 7'h20 : 7'h00, b[4:0]};
						immv  = {27'b0, b[4:0]};
					end else begin
						imm12 = b[11:0];
						immv  = {{20{b[11]}}, b[11:0]};
					end
					issue(i_type(imm12, 5'd1, f3[2:0], 5'd4, OP_IMM), rand_pc(), r);
					check_word("op-imm alu_result", r.alu_result,
						alu_model(f3[2:0], alt, a, immv));
				end
			end
		end
	endtask

	task automatic upper_imm_test();
		logic [19:0]     u;
		logic [xlen-1:0] at_pc;
		ex_result_t      r;
		repeat (4) begin
			u     = 20'($random(seed));
			at_pc = rand_pc();
			issue(u_type(u, 5'd7, OP_LUI), at_pc, r);
			check_word("lui alu_result", r.alu_result, {u, 12'b0});
			issue(u_type(u, 5'd7, OP_AUIPC), at_pc, r);
			check_word("auipc alu_result", r.alu_result, at_pc + {u, 12'b0});
			check_bit("auipc rd_wr", r.rd_wr, 1'b1);
		end
	endtask

	task automatic branch_test();
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] at_pc;
		logic [12:0]     off;
		ex_result_t      r;
		for (int pair = 0; pair < 3; pair++) begin
			a = $random(seed);
			b = $random(seed);
			if (pair == 0) begin
				b = a;
			end else begin
				a[31] = (pair == 1);  // negative against positive and then swapped
				b[31] = (pair == 2);
			end
			load_reg(5'd1, a);
			load_reg(5'd2, b);
			for (int f = 0; f < 8; f++) begin
				if (f == 2 || f == 3)
					continue;
				off    = 13'($random(seed));
				off[0] = 1'b0;
				at_pc  = rand_pc();
				issue(b_type(off, 5'd2, 5'd1, f[2:0]), at_pc, r);
				check_bit("branch take_branch", r.take_branch, branch_model(f[2:0], a, b));
				check_word("branch target_pc", r.target_pc, at_pc + {{19{off[12]}}, off});
				check_bit("branch rd_wr", r.rd_wr, 1'b0);
			end
		end
	endtask

	task automatic jump_test();
		logic [20:0]     joff;
		logic [11:0]     jimm;
		logic [xlen-1:0] base;
		logic [xlen-1:0] at_pc;
		logic [xlen-1:0] link;
		ex_result_t      r;
		ex_result_t      exp;
		joff    = 21'($random(seed));
		joff[0] = 1'b0;
		at_pc   = rand_pc();
		issue(j_type(joff, 5'd8), at_pc, r);
		exp             = '0;
		exp.valid       = 1'b1;
		exp.take_branch = 1'b1;
		exp.target_pc   = at_pc + {{11{joff[20]}}, joff};
		exp.alu_result  = at_pc + 4;
		exp.rd          = 5'd8;
		exp.rd_wr       = 1'b1;
		check_result("jal", r, exp);
		read_reg(5'd8, link);
		check_word("jal link x8", link, at_pc + 4);

		base = $random(seed);  // may be odd
		jimm = 12'($random(seed));
		load_reg(5'd9, base);
		at_pc = rand_pc();
		issue(i_type(jimm, 5'd9, 3'b000, 5'd10, OP_JALR), at_pc, r);
		exp.target_pc  = (base + {{20{jimm[11]}}, jimm}) & ~32'h1;
		exp.alu_result = at_pc + 4;
		exp.rd         = 5'd10;
		check_result("jalr", r, exp);
		read_reg(5'd10, link);
		check_word("jalr link x10", link, at_pc + 4);
	endtask

	task automatic chain_illegal_test();
		logic [11:0]     inc;
		logic [xlen-1:0] acc;
		logic [xlen-1:0] value;
		ex_result_t      r;
		acc = '0;
		for (int i = 0; i < 8; i++) begin
			inc = 12'($random(seed));
			@(posedge clk);
			inst_valid <= 1'b1;
			inst       <= i_type(inc, (i == 0) ? 5'd0 : 5'd11, 3'b000, 5'd11, OP_IMM);
			inst_pc    <= 32'h400 + 32'(i * 4);
			if (i > 0) begin
				wait_valid(r);  // previous addi with no idle cycle between
				check_word("chain alu_result", r.alu_result, acc);
			end
			acc = acc + {{20{inc[11]}}, inc};
		end
		@(posedge clk);
		inst_valid <= 1'b0;
		wait_valid(r);
		check_word("chain last alu_result", r.alu_result, acc);
		read_reg(5'd11, value);
		check_word("chain x11", value, acc);

		value = $random(seed);
		load_reg(5'd6, value);
		issue({12'h0, 5'd0, 3'b010, 5'd6, 7'b0000011}, rand_pc(), r);  // lw x6
		check_bit("illegal flag", r.illegal, 1'b1);
		check_bit("illegal rd_wr", r.rd_wr, 1'b0);
		check_bit("illegal take_branch", r.take_branch, 1'b0);
		read_reg(5'd6, acc);
		check_word("illegal x6 kept", acc, value);
	endtask

	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		inst_valid  = 1'b0;
		inst        = '0;
		inst_pc     = '0;
		err_count   = 0;
		check_count = 0;
		seed        = 32'h8e5d0dd6;
		reset_state_test();
		alu_ops_test();
		upper_imm_test();
		branch_test();
		jump_test();
		chain_illegal_test();
		$display("checks run: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns

module alu (
	input  logic [ex_pkg::xlen-1:0] opa,
	input  logic [ex_pkg::xlen-1:0] opb,
	input  logic [ex_pkg::xlen-1:0] br_cond_opa,
	input  logic [ex_pkg::xlen-1:0] br_cond_opb,
	input  ex_pkg::alu_func_e       func,
	input  logic [2:0]              funct3,
	output logic [ex_pkg::xlen-1:0] result,
	output logic                    brcond_result
);
	import ex_pkg::*;

	logic [shamt_w-1:0] shamt;
	logic               lt_s;
	logic               lt_u;

	assign shamt = opb[shamt_w-1:0];  // low bits only
	assign lt_s  = $signed(opa) < $signed(opb);
	assign lt_u  = opa < opb;

	always_comb begin
		case (func)
			ALU_ADD:  result = opa + opb;
			ALU_SUB:  result = opa - opb;
			ALU_SLT:  result = {{(xlen-1){1'b0}}, lt_s};
			ALU_SLTU: result = {{(xlen-1){1'b0}}, lt_u};
			ALU_AND:  result = opa & opb;
			ALU_OR:   result = opa | opb;
			ALU_XOR:  result = opa ^ opb;
			ALU_SLL:  result = opa << shamt;
			ALU_SRL:  result = opa >> shamt;
			ALU_SRA:  result = $signed(opa) >>> shamt;  // sign fill
			default:  result = '0;
		endcase
	end

	// branch compare on the register operands
	always_comb begin
		case (funct3)
			3'b000:  brcond_result = (br_cond_opa == br_cond_opb);  // beq
			3'b001:  brcond_result = (br_cond_opa != br_cond_opb);  // bne
			3'b100:  brcond_result = $signed(br_cond_opa) < $signed(br_cond_opb);  // blt
			3'b101:  brcond_result = $signed(br_cond_opa) >= $signed(br_cond_opb);  // bge
			3'b110:  brcond_result = br_cond_opa < br_cond_opb;  // bltu
			3'b111:  brcond_result = br_cond_opa >= br_cond_opb;  // bgeu
			default: brcond_result = 1'b0;
		endcase
	end

endmodule

// File: verilog/ex_pkg.sv
package ex_pkg;

	localparam int xlen = 32;           // data and address width
	localparam int nregs = 32;          // architectural registers
	localparam int shamt_w = $clog2(xlen);
	localparam logic [6:0] f7_alt = 7'b0100000;  // sub / sra selector in funct7

	// rv32i major opcodes handled by the decoder
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD  = 5'h00,           // zero so a cleared bundle adds
		ALU_SUB  = 5'h01,
		ALU_SLT  = 5'h02,
		ALU_SLTU = 5'h03,
		ALU_AND  = 5'h04,
		ALU_OR   = 5'h05,
		ALU_XOR  = 5'h06,
		ALU_SLL  = 5'h07,
		ALU_SRL  = 5'h08,
		ALU_SRA  = 5'h09
	} alu_func_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'd0,
		OPA_IS_PC   = 2'd1,
		OPA_IS_ZERO = 2'd2
	} opa_sel_e;

	typedef enum logic [1:0] {
		OPB_IS_RS2 = 2'd0,
		OPB_IS_IMM = 2'd1,
		OPB_IS_4   = 2'd2
	} opb_sel_e;

	// registered decode bundle, id/ex boundary
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] imm;
		logic [xlen-1:0] rega;
		logic [xlen-1:0] regb;
		logic [xlen-1:0] pc_add_opa;  // base of the target adder
		opa_sel_e        opa_sel;
		opb_sel_e        opb_sel;
		alu_func_e       alu_func;
		logic [2:0]      funct3;
		logic            cond_branch;
		logic            uncond_branch;
		logic [4:0]      rd;
		logic            rd_wr;
		logic            valid;
		logic            illegal;
	} id_ex_t;

	typedef struct packed {
		logic            valid;
		logic            illegal;
		logic            take_branch;
		logic [xlen-1:0] target_pc;
		logic [xlen-1:0] alu_result;
		logic [4:0]      rd;
		logic            rd_wr;
	} ex_result_t;

	typedef struct packed {
		logic            wr_en;
		logic [4:0]      addr;
		logic [xlen-1:0] data;
	} wb_t;

endpackage

// File: verilog/ex_stage.sv
`timescale 1ns/1ns

module ex_stage (
	input  ex_pkg::id_ex_t     id_ex,
	output ex_pkg::ex_result_t result
);
	import ex_pkg::*;

	logic [xlen-1:0] opa_mux_out;
	logic [xlen-1:0] opb_mux_out;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] target_sum;
	logic            brcond;

	always_comb begin
		case (id_ex.opa_sel)
			OPA_IS_PC:   opa_mux_out = id_ex.pc;
			OPA_IS_ZERO: opa_mux_out = '0;
			default:     opa_mux_out = id_ex.rega;
		endcase
	end

	always_comb begin
		case (id_ex.opb_sel)
			OPB_IS_IMM: opb_mux_out = id_ex.imm;
			OPB_IS_4:   opb_mux_out = xlen'(4);  // link address offset
			default:    opb_mux_out = id_ex.regb;
		endcase
	end

	alu i_alu (
		.opa           (opa_mux_out),
		.opb           (opb_mux_out),
		.br_cond_opa   (id_ex.rega),
		.br_cond_opb   (id_ex.regb),
		.func          (id_ex.alu_func),
		.funct3        (id_ex.funct3),
		.result        (alu_out),
		.brcond_result (brcond)
	);

	assign target_sum = id_ex.pc_add_opa + id_ex.imm;

	always_comb begin
		result.valid       = id_ex.valid;
		result.illegal     = id_ex.illegal;
		result.take_branch = id_ex.valid &
			(id_ex.uncond_branch | (id_ex.cond_branch & brcond));
		// jalr clears bit 0, jal targets are even already
		result.target_pc   = {target_sum[xlen-1:1], target_sum[0] & ~id_ex.uncond_branch};
		result.alu_result  = alu_out;
		result.rd          = id_ex.rd;
		result.rd_wr       = id_ex.rd_wr;
	end

	// decoder strips branch flags from illegal words
	always_comb begin
		assert (!result.take_branch || (result.valid && !result.illegal))
			else $error("take_branch without a valid legal instruction");
	end

endmodule

// File: verilog/exec_core.sv
`timescale 1ns/1ns

module exec_core (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    inst_valid,
	input  logic [31:0]             inst,
	input  logic [ex_pkg::xlen-1:0] pc,
	output ex_pkg::ex_result_t      result
);
	import ex_pkg::*;

	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	id_ex_t          id_ex;
	wb_t             wb;

	inst_decoder i_inst_decoder (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (pc),
		.rs1_addr   (rs1_addr),
		.rs2_addr   (rs2_addr),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.id_ex      (id_ex)
	);

	reg_file i_reg_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb       (wb)
	);

	ex_stage i_ex_stage (
		.id_ex  (id_ex),
		.result (result)
	);

	// writeback lands on the next edge, bypassed to decode meanwhile
	assign wb = '{
		wr_en: result.valid & result.rd_wr & ~result.illegal,
		addr:  result.rd,
		data:  result.alu_result
	};

endmodule

// File: verilog/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   inst_valid,
	input  logic [31:0]            inst,
	input  logic [ex_pkg::xlen-1:0] pc,
	output logic [4:0]             rs1_addr,
	output logic [4:0]             rs2_addr,
	input  logic [ex_pkg::xlen-1:0] rs1_data,
	input  logic [ex_pkg::xlen-1:0] rs2_data,
	output ex_pkg::id_ex_t         id_ex
);
	import ex_pkg::*;

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_j;
	id_ex_t          dec;

	// funct3 to alu function, shared by op and op-imm
	function automatic alu_func_e f3_func(input logic [2:0] f3, input logic sub,
			input logic sra);
		case (f3)
			3'b000:  f3_func = sub ? ALU_SUB : ALU_ADD;
			3'b001:  f3_func = ALU_SLL;
			3'b010:  f3_func = ALU_SLT;
			3'b011:  f3_func = ALU_SLTU;
			3'b100:  f3_func = ALU_XOR;
			3'b101:  f3_func = sra ? ALU_SRA : ALU_SRL;
			3'b110:  f3_func = ALU_OR;
			default: f3_func = ALU_AND;
		endcase
	endfunction

	assign opcode   = opcode_e'(inst[6:0]);
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];

	assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec            = '0;
		dec.valid      = inst_valid;
		dec.pc         = pc;
		dec.rega       = rs1_data;
		dec.regb       = rs2_data;
		dec.pc_add_opa = pc;
		dec.funct3     = funct3;
		dec.rd         = inst[11:7];
		dec.imm        = imm_i;
		dec.opa_sel    = OPA_IS_RS1;
		dec.opb_sel    = OPB_IS_IMM;
		dec.alu_func   = ALU_ADD;
		case (opcode)
			OP_LUI: begin
				dec.opa_sel = OPA_IS_ZERO;  // 0 + imm
				dec.imm     = imm_u;
				dec.rd_wr   = 1'b1;
			end
			OP_AUIPC: begin
				dec.opa_sel = OPA_IS_PC;
				dec.imm     = imm_u;
				dec.rd_wr   = 1'b1;
			end
			OP_JAL: begin
				dec.opa_sel       = OPA_IS_PC;  // link = pc + 4
				dec.opb_sel       = OPB_IS_4;
				dec.imm           = imm_j;
				dec.uncond_branch = 1'b1;
				dec.rd_wr         = 1'b1;
			end
			OP_JALR: begin
				dec.opa_sel       = OPA_IS_PC;
				dec.opb_sel       = OPB_IS_4;
				dec.pc_add_opa    = rs1_data;  // target is rs1 + imm
				dec.uncond_branch = 1'b1;
				dec.rd_wr         = 1'b1;
				dec.illegal       = (funct3 != 3'b000);
			end
			OP_BRANCH: begin
				dec.opa_sel     = OPA_IS_PC;
				dec.imm         = imm_b;
				dec.cond_branch = 1'b1;
				dec.illegal     = (funct3 == 3'b010) || (funct3 == 3'b011);
			end
			OP_IMM: begin
				dec.alu_func = f3_func(funct3, 1'b0, funct7[5]);
				dec.rd_wr    = 1'b1;
				dec.illegal  = ((funct3 == 3'b001) && (funct7 != 7'b0)) ||
					((funct3 == 3'b101) && (funct7 != 7'b0) && (funct7 != f7_alt));
			end
			OP_REG: begin
				dec.opb_sel  = OPB_IS_RS2;
				dec.alu_func = f3_func(funct3, funct7[5], funct7[5]);
				dec.rd_wr    = 1'b1;
				dec.illegal  = (funct7 != 7'b0) && !((funct7 == f7_alt) &&
					((funct3 == 3'b000) || (funct3 == 3'b101)));
			end
			default: dec.illegal = 1'b1;  // load, store, system etc
		endcase
		if (dec.illegal) begin
			// no write and no redirect
			dec.rd_wr         = 1'b0;
			dec.cond_branch   = 1'b0;
			dec.uncond_branch = 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex <= '0;
		end else begin
			id_ex <= dec;
		end
	end

	// an illegal instruction accepted now must reach execute without a write
	assert property (@(posedge clk) disable iff (!arst_n)
		(inst_valid && dec.illegal) |=> (id_ex.valid && id_ex.illegal && !id_ex.rd_wr))
		else $error("illegal instruction issued with rd_wr set");

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [4:0]              rs1_addr,
	input  logic [4:0]              rs2_addr,
	output logic [ex_pkg::xlen-1:0] rs1_data,
	output logic [ex_pkg::xlen-1:0] rs2_data,
	input  ex_pkg::wb_t             wb
);
	import ex_pkg::*;

	logic [xlen-1:0] regs [nregs];

	// read with x0 tied low and same-cycle write forwarded
	function automatic logic [xlen-1:0] rd_port(input logic [4:0] addr);
		if (addr == 5'd0) begin
			rd_port = '0;
		end else if (wb.wr_en && (wb.addr == addr)) begin
			rd_port = wb.data;  // write-through
		end else begin
			rd_port = regs[addr];
		end
	endfunction

	always_comb begin
		rs1_data = rd_port(rs1_addr);
		rs2_data = rd_port(rs2_addr);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < nregs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.wr_en && (wb.addr != 5'd0)) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// x0 reads as zero whatever was written to it
	assert property (@(posedge clk) disable iff (!arst_n)
		((rs1_addr != 5'd0) || (rs1_data == '0)) && ((rs2_addr != 5'd0) || (rs2_data == '0)))
		else $error("read of x0 returned nonzero data");

endmodule
